/* verilog/doppler_params.svh */
`ifndef DOPPLER_PARAMS_SVH
`define DOPPLER_PARAMS_SVH

// ------------------------------------------------------------------------
// Settings register addresses
// ------------------------------------------------------------------------
`define SR_THRESHOLD    8'd194
`define SR_OFFSET       8'd195
`define SR_ZC_AVG_LOG2  8'd197
`define SR_RATE_HZ      8'd198

// Register reset values
`define THRESHOLD_RESET 32'd0
`define OFFSET_RESET    32'd0
`define AVG_LOG2_RESET  8'd0
`define RATE_HZ_RESET   32'd1000000000

// Datapath widths
`define SAMPLE_W        16
`define FREQ_W          32

// Longest moving average is 2**7 values
`define AVG_MAX_LOG2    7

// Readback filler for unmapped addresses
`define RB_BAD          64'h0BADC0DE0BADC0DE

`endif

/* verilog/doppler_pkg.sv */
`include "doppler_params.svh"

package doppler_pkg;

  // One complex baseband beat
  typedef struct packed {
    logic signed [`SAMPLE_W-1:0] i;
    logic signed [`SAMPLE_W-1:0] q;
  } iq_sample_t;

  typedef struct packed {
    logic signed [`SAMPLE_W-1:0] i_part;
    logic signed [`SAMPLE_W-1:0] q_part;
  } set_halves_t;

  // Settings word, either one value or per-channel halves
  typedef union packed {
    logic [31:0] raw;
    set_halves_t halves;
  } set_word_u;

  typedef struct packed {
    logic      stb;
    logic [7:0] addr;
    set_word_u data;
  } set_bus_t;

  // Divider request, chan 0 is I and chan 1 is Q
  typedef struct packed {
    logic                      chan;
    logic signed [`FREQ_W-1:0] period;
  } div_req_t;

  typedef struct packed {
    logic                      chan;
    logic signed [`FREQ_W-1:0] freq;
  } div_rsp_t;

endpackage

/* verilog/doppler_settings.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module doppler_settings
  import doppler_pkg::*;
(
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  set_bus_t                  i_set,
  input  logic [7:0]                i_rb_addr,
  input  logic signed [`FREQ_W-1:0] i_period_i,
  input  logic signed [`FREQ_W-1:0] i_period_q,
  input  logic signed [`FREQ_W-1:0] i_avg_i,
  input  logic signed [`FREQ_W-1:0] i_avg_q,
  output set_word_u                 o_threshold,
  output set_word_u                 o_offset,
  output logic [`FREQ_W-1:0]        o_rate_hz,
  output logic [7:0]                o_avg_log2,
  output logic                      o_avg_clear,
  output logic [63:0]               o_rb_data
);

  // ------------------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------------------
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      o_threshold <= `THRESHOLD_RESET;
      o_offset    <= `OFFSET_RESET;
      o_rate_hz   <= `RATE_HZ_RESET;
      o_avg_log2  <= `AVG_LOG2_RESET;
      o_avg_clear <= 1'b0;
    end else begin
      o_avg_clear <= 1'b0;
      if (i_set.stb) begin
        case (i_set.addr)
          `SR_THRESHOLD: o_threshold <= i_set.data;
          `SR_OFFSET:    o_offset <= i_set.data;
          `SR_RATE_HZ:   o_rate_hz <= i_set.data.raw;
          `SR_ZC_AVG_LOG2: begin
            o_avg_log2  <= i_set.data.raw[7:0];
            o_avg_clear <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // ------------------------------------------------------------------------
  // Readback
  // ------------------------------------------------------------------------
  always_comb begin
    case (i_rb_addr)
      8'd0:    o_rb_data = {56'd0, o_avg_log2};
      8'd1:    o_rb_data = {i_period_i, i_period_q};
      8'd2:    o_rb_data = {i_avg_i, i_avg_q};
      8'd3:    o_rb_data = {o_threshold.halves.i_part, o_threshold.halves.q_part,
                            o_offset.halves.i_part, o_offset.halves.q_part};
      8'd4:    o_rb_data = {32'd0, o_rate_hz};
      default: o_rb_data = `RB_BAD;
    endcase
  end

  avg_log2_in_range : assert property (
    @(posedge ce_clk) disable iff (ce_rst) o_avg_log2 <= 8'(`AVG_MAX_LOG2))
    else $error("average exponent out of range");

endmodule

/* verilog/zero_crossing_detect.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module zero_crossing_detect
  import doppler_pkg::*;
#(
  parameter bit IS_Q_PART = 1'b0
) (
  input  logic                        ce_clk,
  input  logic                        ce_rst,
  input  logic signed [`SAMPLE_W-1:0] i_sample,
  input  logic                        i_other_sign,
  input  logic                        i_valid,
  input  logic signed [`SAMPLE_W-1:0] i_threshold,
  input  logic signed [`SAMPLE_W-1:0] i_offset,
  input  logic                        i_grant,
  output div_req_t                    o_req,
  output logic                        o_req_valid,
  output logic                        o_busy,
  output logic signed [`FREQ_W-1:0]   o_last_period
);

  logic signed [`SAMPLE_W:0] x;
  logic signed [`SAMPLE_W:0] thr;
  logic                      armed;
  logic                      seen_first;
  logic [`FREQ_W-1:0]        count;
  logic [`FREQ_W-1:0]        period;
  logic signed [`FREQ_W-1:0] req_period;
  logic                      positive;
  logic                      rising;

  // One extra bit so the offset never wraps
  assign x = $signed({i_sample[`SAMPLE_W-1], i_sample})
           - $signed({i_offset[`SAMPLE_W-1], i_offset});
  assign thr = $signed({i_threshold[`SAMPLE_W-1], i_threshold});

  assign rising = armed && (x > thr);
  // Crossing sample is part of the period
  assign period = count + 1'b1;

  // Rotation direction from the other channel
  assign positive   = IS_Q_PART ? ~i_other_sign : i_other_sign;
  assign req_period = positive ? $signed(period) : -$signed(period);

  // Stall input until a pending request is taken
  assign o_busy = o_req_valid & ~i_grant;

  // ------------------------------------------------------------------------
  // Hysteresis and period counter
  // ------------------------------------------------------------------------
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      armed         <= 1'b0;
      seen_first    <= 1'b0;
      count         <= '0;
      o_req_valid   <= 1'b0;
      o_last_period <= '0;
    end else begin
      if (o_req_valid && i_grant) begin
        o_req_valid <= 1'b0;
      end
      if (i_valid) begin
        if (rising) begin
          armed      <= 1'b0;
          seen_first <= 1'b1;
          count      <= '0;
          // First crossing only starts the count
          if (seen_first) begin
            o_req_valid   <= 1'b1;
            o_last_period <= req_period;
          end
        end else begin
          count <= period;
          if (x < -thr) begin
            armed <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_valid && rising && seen_first) begin
      o_req.chan   <= IS_Q_PART;
      o_req.period <= req_period;
    end
  end

  no_zero_period : assert property (
    @(posedge ce_clk) disable iff (ce_rst) o_req_valid |-> (o_req.period != '0))
    else $error("zero period requested");

endmodule

/* verilog/div_arbiter.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module div_arbiter
  import doppler_pkg::*;
(
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  div_req_t                  i_req_i,
  input  div_req_t                  i_req_q,
  input  logic                      i_valid_i,
  input  logic                      i_valid_q,
  input  logic                      i_div_ready,
  input  div_rsp_t                  i_rsp,
  input  logic                      i_rsp_valid,
  output logic                      o_grant_i,
  output logic                      o_grant_q,
  output div_req_t                  o_div_req,
  output logic                      o_div_valid,
  output logic                      o_rsp_i_valid,
  output logic                      o_rsp_q_valid,
  output logic signed [`FREQ_W-1:0] o_rsp_freq
);

  logic last_q;
  logic pick_q;

  // Q wins when alone or when I had the last turn
  assign pick_q = i_valid_q & (~i_valid_i | ~last_q);

  assign o_div_valid = i_valid_i | i_valid_q;
  assign o_div_req   = pick_q ? i_req_q : i_req_i;
  assign o_grant_i   = i_div_ready & i_valid_i & ~pick_q;
  assign o_grant_q   = i_div_ready & pick_q;

  // Results go back to the channel named in the tag
  assign o_rsp_i_valid = i_rsp_valid & ~i_rsp.chan;
  assign o_rsp_q_valid = i_rsp_valid & i_rsp.chan;
  assign o_rsp_freq    = i_rsp.freq;

  // Starts as if Q went last so I is served first
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      last_q <= 1'b1;
    end else if (o_div_valid && i_div_ready) begin
      last_q <= pick_q;
    end
  end

  one_grant : assert property (
    @(posedge ce_clk) disable iff (ce_rst) !(o_grant_i && o_grant_q))
    else $error("divider granted to both channels");

endmodule

/* verilog/freq_divider.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module freq_divider
  import doppler_pkg::*;
(
  input  logic               ce_clk,
  input  logic               ce_rst,
  input  div_req_t           i_req,
  input  logic               i_valid,
  input  logic [`FREQ_W-1:0] i_rate_hz,
  output logic               o_ready,
  output div_rsp_t           o_rsp,
  output logic               o_rsp_valid
);

  localparam int CNT_W = $clog2(`FREQ_W) + 1;

  logic               busy;
  logic [CNT_W-1:0]   step;
  logic [`FREQ_W-1:0] dvs;
  logic [`FREQ_W-1:0] quo;
  logic [`FREQ_W-1:0] rem;
  logic [`FREQ_W:0]   rem_shift;
  logic               neg;
  logic               chan;
  logic               start;
  logic               last_step;

  assign o_ready   = ~busy;
  assign start     = i_valid & o_ready;
  assign last_step = (step == CNT_W'(`FREQ_W));

  // Dividend bits shift out of quo into the remainder
  assign rem_shift = {rem, quo[`FREQ_W-1]};

  // ------------------------------------------------------------------------
  // Control: accept, 32 iterations, sign and result
  // ------------------------------------------------------------------------
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      busy        <= 1'b0;
      step        <= '0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy        <= 1'b0;
          o_rsp_valid <= 1'b1;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  // Restoring division of magnitudes
  always_ff @(posedge ce_clk) begin
    if (start) begin
      dvs  <= i_req.period[`FREQ_W-1] ? -i_req.period : i_req.period;
      quo  <= i_rate_hz;
      rem  <= '0;
      neg  <= i_req.period[`FREQ_W-1];
      chan <= i_req.chan;
    end else if (busy && !last_step) begin
      if (rem_shift >= {1'b0, dvs}) begin
        rem <= `FREQ_W'(rem_shift - {1'b0, dvs});
        quo <= {quo[`FREQ_W-2:0], 1'b1};
      end else begin
        rem <= rem_shift[`FREQ_W-1:0];
        quo <= {quo[`FREQ_W-2:0], 1'b0};
      end
    end else if (busy) begin
      o_rsp.chan <= chan;
      o_rsp.freq <= neg ? -$signed(quo) : $signed(quo);
    end
  end

endmodule

/* verilog/freq_moving_avg.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module freq_moving_avg
  import doppler_pkg::*;
(
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  logic signed [`FREQ_W-1:0] i_freq,
  input  logic                      i_valid,
  input  logic [7:0]                i_log2_len,
  input  logic                      i_clear,
  output logic signed [`FREQ_W-1:0] o_avg,
  output logic                      o_avg_valid
);

  localparam int LW       = `AVG_MAX_LOG2;
  localparam int HIST_LEN = 1 << LW;
  localparam int SUM_W    = `FREQ_W + LW;

  logic signed [`FREQ_W-1:0] hist [HIST_LEN];
  logic [HIST_LEN-1:0]       filled;
  logic [LW-1:0]             ptr;
  logic [LW-1:0]             base_ptr;
  logic [LW-1:0]             mask;
  logic signed [SUM_W-1:0]   sum;
  logic signed [SUM_W-1:0]   base_sum;
  logic signed [SUM_W-1:0]   sum_next;
  logic signed [SUM_W-1:0]   sum_shift;
  logic signed [`FREQ_W-1:0] leaving;

  // Window wraps at 2**k entries
  assign mask = LW'((8'd1 << i_log2_len) - 8'd1);

  // A clear in the same cycle starts from an empty window
  assign base_ptr = i_clear ? '0 : ptr;
  assign base_sum = i_clear ? '0 : sum;
  // Unwritten slots count as zero
  assign leaving  = (i_clear || !filled[ptr]) ? '0 : hist[ptr];

  assign sum_next  = base_sum + SUM_W'(i_freq) - SUM_W'(leaving);
  assign sum_shift = sum_next >>> i_log2_len;

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      filled      <= '0;
      ptr         <= '0;
      sum         <= '0;
      o_avg_valid <= 1'b0;
    end else begin
      o_avg_valid <= i_valid;
      if (i_clear) begin
        filled <= '0;
        ptr    <= '0;
        sum    <= '0;
      end
      if (i_valid) begin
        filled[base_ptr] <= 1'b1;
        ptr              <= (base_ptr + 1'b1) & mask;
        sum              <= sum_next;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_valid) begin
      hist[base_ptr] <= i_freq;
      o_avg          <= sum_shift[`FREQ_W-1:0];
    end
  end

endmodule

/* verilog/iq_freq_combine.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module iq_freq_combine
  import doppler_pkg::*;
(
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  logic signed [`FREQ_W-1:0] i_avg_i,
  input  logic                      i_avg_i_valid,
  input  logic signed [`FREQ_W-1:0] i_avg_q,
  input  logic                      i_avg_q_valid,
  input  logic                      i_ready,
  output logic signed [`FREQ_W-1:0] o_est,
  output logic                      o_valid,
  output logic signed [`FREQ_W-1:0] o_avg_i_hold,
  output logic signed [`FREQ_W-1:0] o_avg_q_hold
);

  logic signed [`FREQ_W-1:0] next_i;
  logic signed [`FREQ_W-1:0] next_q;
  logic [`FREQ_W:0]          pair_sum;
  logic                      update;

  assign update = i_avg_i_valid | i_avg_q_valid;
  assign next_i = i_avg_i_valid ? i_avg_i : o_avg_i_hold;
  assign next_q = i_avg_q_valid ? i_avg_q : o_avg_q_hold;

  // Sign extend, add, drop the LSB for the mean
  assign pair_sum = {next_i[`FREQ_W-1], next_i} + {next_q[`FREQ_W-1], next_q};

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      o_avg_i_hold <= '0;
      o_avg_q_hold <= '0;
      o_valid      <= 1'b0;
    end else if (update) begin
      o_avg_i_hold <= next_i;
      o_avg_q_hold <= next_q;
      o_valid      <= 1'b1;
    end else if (o_valid && i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Newer estimate overwrites one still waiting
  always_ff @(posedge ce_clk) begin
    if (update) begin
      o_est <= pair_sum[`FREQ_W:1];
    end
  end

endmodule

/* verilog/doppler_tracker.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module doppler_tracker
  import doppler_pkg::*;
(
  input  logic                      ce_clk,
  input  logic                      ce_rst,
  input  set_bus_t                  i_set,
  input  iq_sample_t                i_sample,
  input  logic                      i_sample_valid,
  output logic                      o_sample_ready,
  output logic signed [`FREQ_W-1:0] o_freq_est,
  output logic                      o_freq_valid,
  input  logic                      i_freq_ready,
  input  logic [7:0]                i_rb_addr,
  output logic [63:0]               o_rb_data
);

  // ------------------------------------------------------------------------
  // Wires
  // ------------------------------------------------------------------------
  set_word_u                 threshold;
  set_word_u                 offset;
  logic [`FREQ_W-1:0]        rate_hz;
  logic [7:0]                avg_log2;
  logic                      avg_clear;
  logic                      sample_fire;
  div_req_t                  req_i;
  div_req_t                  req_q;
  logic                      req_valid_i;
  logic                      req_valid_q;
  logic                      busy_i;
  logic                      busy_q;
  logic signed [`FREQ_W-1:0] period_i;
  logic signed [`FREQ_W-1:0] period_q;
  logic                      grant_i;
  logic                      grant_q;
  div_req_t                  div_req;
  logic                      div_valid;
  logic                      div_ready;
  div_rsp_t                  div_rsp;
  logic                      div_rsp_valid;
  logic                      rsp_i_valid;
  logic                      rsp_q_valid;
  logic signed [`FREQ_W-1:0] rsp_freq;
  logic signed [`FREQ_W-1:0] avg_i;
  logic signed [`FREQ_W-1:0] avg_q;
  logic                      avg_i_valid;
  logic                      avg_q_valid;
  logic signed [`FREQ_W-1:0] avg_i_hold;
  logic signed [`FREQ_W-1:0] avg_q_hold;

  assign o_sample_ready = ~(busy_i | busy_q);
  assign sample_fire    = i_sample_valid & o_sample_ready;

  doppler_settings u_settings (
    .ce_clk(ce_clk), .ce_rst(ce_rst), .i_set(i_set), .i_rb_addr(i_rb_addr),
    .i_period_i(period_i), .i_period_q(period_q),
    .i_avg_i(avg_i_hold), .i_avg_q(avg_q_hold),
    .o_threshold(threshold), .o_offset(offset), .o_rate_hz(rate_hz),
    .o_avg_log2(avg_log2), .o_avg_clear(avg_clear), .o_rb_data(o_rb_data));

  // Each channel takes its sign from the other
  zero_crossing_detect #(.IS_Q_PART(1'b0)) u_zc_i (
    .ce_clk(ce_clk), .ce_rst(ce_rst),
    .i_sample(i_sample.i), .i_other_sign(i_sample.q[`SAMPLE_W-1]), .i_valid(sample_fire),
    .i_threshold(threshold.halves.i_part), .i_offset(offset.halves.i_part),
    .i_grant(grant_i), .o_req(req_i), .o_req_valid(req_valid_i),
    .o_busy(busy_i), .o_last_period(period_i));

  zero_crossing_detect #(.IS_Q_PART(1'b1)) u_zc_q (
    .ce_clk(ce_clk), .ce_rst(ce_rst),
    .i_sample(i_sample.q), .i_other_sign(i_sample.i[`SAMPLE_W-1]), .i_valid(sample_fire),
    .i_threshold(threshold.halves.q_part), .i_offset(offset.halves.q_part),
    .i_grant(grant_q), .o_req(req_q), .o_req_valid(req_valid_q),
    .o_busy(busy_q), .o_last_period(period_q));

  div_arbiter u_arbiter (
    .ce_clk(ce_clk), .ce_rst(ce_rst),
    .i_req_i(req_i), .i_req_q(req_q), .i_valid_i(req_valid_i), .i_valid_q(req_valid_q),
    .i_div_ready(div_ready), .i_rsp(div_rsp), .i_rsp_valid(div_rsp_valid),
    .o_grant_i(grant_i), .o_grant_q(grant_q), .o_div_req(div_req), .o_div_valid(div_valid),
    .o_rsp_i_valid(rsp_i_valid), .o_rsp_q_valid(rsp_q_valid), .o_rsp_freq(rsp_freq));

  freq_divider u_divider (
    .ce_clk(ce_clk), .ce_rst(ce_rst), .i_req(div_req), .i_valid(div_valid),
    .i_rate_hz(rate_hz), .o_ready(div_ready), .o_rsp(div_rsp), .o_rsp_valid(div_rsp_valid));

  freq_moving_avg u_avg_i (
    .ce_clk(ce_clk), .ce_rst(ce_rst), .i_freq(rsp_freq), .i_valid(rsp_i_valid),
    .i_log2_len(avg_log2), .i_clear(avg_clear), .o_avg(avg_i), .o_avg_valid(avg_i_valid));

  freq_moving_avg u_avg_q (
    .ce_clk(ce_clk), .ce_rst(ce_rst), .i_freq(rsp_freq), .i_valid(rsp_q_valid),
    .i_log2_len(avg_log2), .i_clear(avg_clear), .o_avg(avg_q), .o_avg_valid(avg_q_valid));

  iq_freq_combine u_combine (
    .ce_clk(ce_clk), .ce_rst(ce_rst),
    .i_avg_i(avg_i), .i_avg_i_valid(avg_i_valid),
    .i_avg_q(avg_q), .i_avg_q_valid(avg_q_valid), .i_ready(i_freq_ready),
    .o_est(o_freq_est), .o_valid(o_freq_valid),
    .o_avg_i_hold(avg_i_hold), .o_avg_q_hold(avg_q_hold));

endmodule

/* tb/doppler_tracker_tb.sv */
`timescale 1ns/100ps
`include "doppler_params.svh"

module doppler_tracker_tb
  import doppler_pkg::*;
;

  localparam int TOTAL_BEATS = 2100;
  localparam int CYCLE_LIMIT = TOTAL_BEATS * 64 + 2000;

  logic                      ce_clk;
  logic                      ce_rst;
  set_bus_t                  i_set;
  iq_sample_t                i_sample;
  logic                      i_sample_valid;
  logic                      o_sample_ready;
  logic signed [`FREQ_W-1:0] o_freq_est;
  logic                      o_freq_valid;
  logic                      i_freq_ready;
  logic [7:0]                i_rb_addr;
  logic [63:0]               o_rb_data;

  // Model registers and detector state per channel
  // Index 0 is I and index 1 is Q
  logic signed [15:0] thr [2];
  logic signed [15:0] off [2];
  logic [31:0]        rate;
  int                 avg_k;
  bit                 armed [2];
  bit                 seen [2];
  int                 cnt [2];
  logic signed [31:0] lp [2];
  int                 hist [2][$];
  int                 avg_list [2][$];
  // Candidate average index pairs packed as i*65536+q
  int                 cands [$];

  // Stimulus state
  int  quad;
  int  dwell;
  int  amp;
  int  dir;
  int  to_send;
  int  sent;
  int  model_beats;
  int  cycles;
  bit  accepted;
  bit  running;
  bit  bp;

  doppler_tracker uut (
    .ce_clk(ce_clk), .ce_rst(ce_rst), .i_set(i_set), .i_sample(i_sample),
    .i_sample_valid(i_sample_valid), .o_sample_ready(o_sample_ready),
    .o_freq_est(o_freq_est), .o_freq_valid(o_freq_valid), .i_freq_ready(i_freq_ready),
    .i_rb_addr(i_rb_addr), .o_rb_data(o_rb_data));

  initial begin
    ce_clk = 1'b0;
    forever #50 ce_clk = ~ce_clk;
  end

  // --------------------------------------------------------------------------
  // Reporting and checks
  // --------------------------------------------------------------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_rb(input logic [7:0] addr, input logic [63:0] exp);
    i_rb_addr = addr;
    #1;
    check_value($sformatf("readback %0d", addr), exp, o_rb_data);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge ce_clk);
    #1;
    i_set.stb      = 1'b1;
    i_set.addr     = addr;
    i_set.data.raw = data;
    @(posedge ce_clk);
    #1;
    i_set.stb = 1'b0;
    if (addr == `SR_ZC_AVG_LOG2) begin
      avg_k = data;
      hist[0].delete();
      hist[1].delete();
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic zc_step(input int ch, input logic signed [15:0] s, input bit positive);
    int     x;
    int     p;
    longint q;
    longint sum;
    int     n;
    x = int'(s) - int'(off[ch]);
    if (armed[ch] && x > int'(thr[ch])) begin
      armed[ch] = 1'b0;
      if (seen[ch]) begin
        p = positive ? cnt[ch] + 1 : -(cnt[ch] + 1);
        lp[ch] = p;
        q = longint'(rate) / longint'(cnt[ch] + 1);
        q = (p < 0) ? -q : q;
        hist[ch].push_back(int'(q[31:0]));
        sum = 0;
        n = hist[ch].size();
        for (int j = n - 1; j >= 0 && j >= n - (1 << avg_k); j--) begin
          sum += longint'(hist[ch][j]);
        end
        sum = sum >>> avg_k;
        avg_list[ch].push_back(int'(sum[31:0]));
      end
      seen[ch] = 1'b1;
      cnt[ch]  = 0;
    end else begin
      cnt[ch]++;
      if (x < -int'(thr[ch])) armed[ch] = 1'b1;
    end
  endtask

  task automatic model_beat(input logic signed [15:0] si, input logic signed [15:0] sq);
    zc_step(0, si, sq[15]);
    zc_step(1, sq, ~si[15]);
  endtask

  task automatic match_estimate(input logic [63:0] pair, input logic signed [31:0] est);
    int     next [$];
    int     ci;
    int     cq;
    int     lim;
    int     key;
    bit     dup;
    longint s;
    lim = bp ? 3 : 1;
    foreach (cands[n]) begin
      ci = cands[n] / 65536;
      cq = cands[n] % 65536;
      for (int di = 0; di <= lim; di++) begin
        for (int dq = 0; dq <= lim; dq++) begin
          if (di + dq == 0 || (!bp && di + dq != 1)) continue;
          if (ci + di >= avg_list[0].size() || cq + dq >= avg_list[1].size()) continue;
          if (avg_list[0][ci + di] != int'(pair[63:32])) continue;
          if (avg_list[1][cq + dq] != int'(pair[31:0])) continue;
          key = (ci + di) * 65536 + cq + dq;
          dup = 1'b0;
          foreach (next[m]) if (next[m] == key) dup = 1'b1;
          if (!dup) next.push_back(key);
        end
      end
    end
    if (next.size() == 0) stop_run("Output estimate matches no pair of model averages");
    cands = next;
    ci = cands[0] / 65536;
    cq = cands[0] % 65536;
    s = (longint'(avg_list[0][ci]) + longint'(avg_list[1][cq])) >>> 1;
    check_value("estimate", 64'(signed'(s[31:0])), 64'(est));
  endtask

  // --------------------------------------------------------------------------
  // Quadrature square wave stimulus with noise
  // --------------------------------------------------------------------------
  task automatic gen_beat();
    int vi;
    int vq;
    if (dwell == 0) begin
      if ($urandom_range(7) == 0) dir = -dir;
      quad  = (quad + dir + 4) % 4;
      dwell = $urandom_range(20, 2);
      amp   = $urandom_range(12000, 4000);
    end
    dwell--;
    vi = (quad == 0 || quad == 3) ? amp : -amp;
    vq = (quad < 2) ? amp : -amp;
    vi = vi + int'(off[0]) + $urandom_range(int'(thr[0])) - int'(thr[0]) / 2;
    vq = vq + int'(off[1]) + $urandom_range(int'(thr[1])) - int'(thr[1]) / 2;
    i_sample.i = vi[15:0];
    i_sample.q = vq[15:0];
  endtask

  always @(posedge ce_clk) begin
    #1;
    if (!ce_rst) begin
      i_freq_ready = bp ? 1'($urandom_range(1)) : 1'b1;
      if (!i_sample_valid || accepted) begin
        accepted = 1'b0;
        if (to_send > 0 && $urandom_range(3) != 0) begin
          gen_beat();
          i_sample_valid = 1'b1;
          to_send--;
          sent++;
        end else begin
          i_sample_valid = 1'b0;
        end
      end
    end
  end

  // Monitor at the falling edge where every signal is settled
  always @(negedge ce_clk) begin
    if (running) begin
      i_rb_addr = 8'd1;
      #1;
      check_value("period readback", {lp[0], lp[1]}, o_rb_data);
      if (o_freq_valid && i_freq_ready) begin
        i_rb_addr = 8'd2;
        #1;
        match_estimate(o_rb_data, o_freq_est);
        i_rb_addr = 8'd1;
      end
      if (i_sample_valid && o_sample_ready) begin
        model_beat(i_sample.i, i_sample.q);
        accepted = 1'b1;
        model_beats++;
      end
    end
  end

  always @(posedge ce_clk) begin
    if (!ce_rst) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) stop_run("Timeout, the DUT stopped making progress");
    end
  end

  task automatic run_phase(input int beats, input bit with_bp);
    int final_key;
    bit done;
    bp       = with_bp;
    running  = 1'b1;
    to_send  = beats;
    done     = 1'b0;
    while (!done) begin
      @(posedge ce_clk);
      final_key = (avg_list[0].size() - 1) * 65536 + avg_list[1].size() - 1;
      if (to_send == 0 && !i_sample_valid) begin
        foreach (cands[n]) if (cands[n] == final_key) done = 1'b1;
      end
    end
    cands    = {final_key};
    bp       = 1'b0;
    running  = 1'b0;
  endtask

  initial begin
    void'($urandom(75262));
    ce_rst         = 1'b1;
    i_set          = '0;
    i_sample       = '0;
    i_sample_valid = 1'b0;
    i_freq_ready   = 1'b1;
    i_rb_addr      = 8'd0;
    thr = '{16'sd0, 16'sd0};
    off = '{16'sd0, 16'sd0};
    rate  = 32'd1000000000;
    avg_k = 0;
    lp    = '{32'sd0, 32'sd0};
    avg_list[0].push_back(0);
    avg_list[1].push_back(0);
    cands.push_back(0);
    quad = 0;
    dwell = 0;
    dir = 1;
    amp = 8000;
    repeat (10) @(posedge ce_clk);
    #1;
    ce_rst = 1'b0;

    // Reset values and unused addresses
    check_rb(8'd0, 64'd0);
    check_rb(8'd1, 64'd0);
    check_rb(8'd2, 64'd0);
    check_rb(8'd3, 64'd0);
    check_rb(8'd4, 64'd1000000000);
    check_rb(8'd5, `RB_BAD);
    check_rb(8'd200, `RB_BAD);

    thr[0] = $urandom_range(2000, 200);
    thr[1] = $urandom_range(2000, 200);
    off[0] = $urandom_range(1000) - 500;
    off[1] = $urandom_range(1000) - 500;
    write_reg(`SR_THRESHOLD, {thr[0], thr[1]});
    write_reg(`SR_OFFSET, {off[0], off[1]});
    write_reg(`SR_ZC_AVG_LOG2, 32'd0);
    check_rb(8'd0, 64'd0);
    check_rb(8'd3, {thr[0], thr[1], off[0], off[1]});

    // Plain division for several rates
    for (int r = 0; r < 3; r++) begin
      rate = $urandom_range(2000000000, 1000000);
      write_reg(`SR_RATE_HZ, rate);
      check_rb(8'd4, {32'd0, rate});
      run_phase(300, 1'b0);
    end

    // Averaging with the history cleared by each exponent write
    write_reg(`SR_ZC_AVG_LOG2, 32'd2);
    check_rb(8'd0, 64'd2);
    run_phase(400, 1'b0);
    write_reg(`SR_ZC_AVG_LOG2, 32'd5);
    check_rb(8'd0, 64'd5);
    run_phase(400, 1'b0);

    run_phase(400, 1'b1);

    check_value("accepted beats", 64'(sent), 64'(model_beats));
    $display("Test passed");
    $finish;
  end

endmodule

/* doppler_tracker.f */
+incdir+verilog
verilog/doppler_pkg.sv
verilog/doppler_settings.sv
verilog/zero_crossing_detect.sv
verilog/div_arbiter.sv
verilog/freq_divider.sv
verilog/freq_moving_avg.sv
verilog/iq_freq_combine.sv
verilog/doppler_tracker.sv
tb/doppler_tracker_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f doppler_tracker.f \
		--top-module doppler_tracker_tb -o doppler_tracker_sim
	./obj_dir/doppler_tracker_sim

clean:
	rm -rf obj_dir
